//--- all.f
lc3b_types_pkg.sv
lc3b_ctrl_pkg.sv
lc3b_ifs.sv
lc3b_regfile.sv
lc3b_alu.sv
lc3b_control_rom.sv
lc3b_hazard_unit.sv
pipeline_datapath.sv
lc3b_cpu.sv
tb_clock_gen.sv
lc3b_asserts.sv
tb_lc3b.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_lc3b -f all.f
./obj_dir/Vtb_lc3b 2>&1 | tee /dev/stderr | grep -qx "test passed"
echo "Simulation reported a pass"

//--- tb_lc3b.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b;
	localparam lc3b_types_pkg::lc3b_word RESET_PC = 16'h0000;
	localparam int PROG_LEN = 40;
	localparam int MAX_WAIT = 5000;  // Cycles until all writes seen

	logic clk;
	logic rst_n;
	lc3b_types_pkg::lc3b_word imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
	lc3b_types_pkg::lc3b_word wb_data;
	lc3b_types_pkg::lc3b_reg wb_dest;
	logic dmem_we;
	logic wb_valid;

	lc3b_types_pkg::lc3b_word imem [64];
	lc3b_types_pkg::lc3b_word dmem [32768];
	lc3b_types_pkg::lc3b_word model_dmem [32768];
	logic [32:0] expect_q [$];  // {store, register or address, data}
	logic [31:0] lfsr;
	int event_count;

	tb_clock_gen #(.PERIOD_NS(100)) clock_gen (.clk);

	lc3b_cpu #(.RESET_PC(RESET_PC)) UUT (.clk, .rst_n, .imem_addr, .imem_rdata, .dmem_addr,
		.dmem_wdata, .dmem_we, .dmem_rdata, .wb_valid, .wb_dest, .wb_data);

	assign imem_rdata = imem[imem_addr[6:1]];     // Word memory, combinational read
	assign dmem_rdata = dmem[dmem_addr[15:1]];

	always @(posedge clk) begin
		if (dmem_we) dmem[dmem_addr[15:1]] <= dmem_wdata;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
	endfunction

	function automatic lc3b_types_pkg::lc3b_word take_bits(input int n);
		lc3b_types_pkg::lc3b_word v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};  // One step per bit
		end
		return v;
	endfunction

	function automatic lc3b_types_pkg::lc3b_word fill_word(input int idx);
		return (16'(idx) * 16'h2b9d) ^ 16'h3c5a;  // Odd multiplier keeps every bit
	endfunction

	function automatic lc3b_types_pkg::lc3b_word sext(input lc3b_types_pkg::lc3b_word v,
			input int bits);
		lc3b_types_pkg::lc3b_word t;
		t = v << (16 - bits);
		return 16'($signed(t) >>> (16 - bits));
	endfunction

	function automatic void build_program();
		int i;
		int t;
		lc3b_types_pkg::lc3b_reg dr, sr1, last_dr;
		lc3b_types_pkg::lc3b_word kind, w;
		logic targeted [64];  // Slots an earlier BR or JMP lands on
		i = 0;
		last_dr = 3'd0;
		for (int k = 0; k < 64; k++) begin
			imem[k] = '0;  // BR never past the end
			targeted[k] = 1'b0;
		end
		while (i < PROG_LEN - 1) begin
			kind = take_bits(3);
			dr = 3'(take_bits(3));
			sr1 = take_bits(1) ? last_dr : 3'(take_bits(3));  // Often chains on last result
			case (kind[2:0])
				3'd0: imem[i] = {4'b0001, dr, sr1, 3'b000, 3'(take_bits(3))};
				3'd1: imem[i] = {4'b0001, dr, sr1, 1'b1, 5'(take_bits(5))};
				3'd2: begin
					w = take_bits(6);
					if (!w[5]) w[4:3] = 2'b00;  // Register form
					imem[i] = {4'b0101, dr, sr1, w[5:0]};
				end
				3'd3: imem[i] = {4'b1001, dr, sr1, 6'h3f};
				3'd4: imem[i] = {4'b1110, dr, 9'(take_bits(9))};
				3'd5: imem[i] = {4'b0110, dr, sr1, 6'(take_bits(6))};
				3'd6: imem[i] = {4'b0111, dr, sr1, 6'(take_bits(6))};
				default: begin
					// JMP slot must not be a landing slot, R7 would be stale there
					if (take_bits(1) && i < PROG_LEN - 2 && !targeted[i + 1]) begin
						// LEA R7 then JMP R7, forward target
						t = i + 2 + int'(take_bits(2));
						if (t > PROG_LEN - 1) t = PROG_LEN - 1;
						targeted[t] = 1'b1;
						imem[i] = {4'b1110, 3'd7, 9'(t - (i + 1))};
						imem[i + 1] = {4'b1100, 3'b000, 3'd7, 6'b000000};
						i++;
					end else begin
						t = i + 1 + int'(take_bits(2));
						if (t > PROG_LEN - 1) t = PROG_LEN - 1;
						targeted[t] = 1'b1;
						imem[i] = {4'b0000, 3'(take_bits(3)), 9'(t - (i + 1))};
					end
				end
			endcase
			last_dr = dr;
			i++;
		end
		imem[PROG_LEN - 1] = 16'h0FFF;  // BR nzp to itself
	endfunction

	// ISA model, fills expect_q with writes and stores in program order
	function automatic logic run_isa_model();
		lc3b_types_pkg::lc3b_word regs [8];
		lc3b_types_pkg::lc3b_word pc, ir, npc, opb, val, addr;
		lc3b_types_pkg::lc3b_reg cc;
		logic writes, sets_cc;
		int steps;
		for (int k = 0; k < 8; k++) regs[k] = '0;
		for (int k = 0; k < 32768; k++) model_dmem[k] = fill_word(k);
		pc = RESET_PC;
		cc = 3'b010;
		steps = 0;
		while (pc != 16'(2 * (PROG_LEN - 1)) && steps < 1000) begin
			ir = imem[pc[6:1]];
			npc = pc + 16'd2;
			opb = ir[5] ? sext(ir[4:0], 5) : regs[ir[2:0]];
			addr = regs[ir[8:6]] + (sext(ir[5:0], 6) << 1);
			writes = 1'b0;
			sets_cc = 1'b1;
			case (lc3b_types_pkg::lc3b_opcode'(ir[15:12]))
				lc3b_types_pkg::op_add: begin
					val = regs[ir[8:6]] + opb;
					writes = 1'b1;
				end
				lc3b_types_pkg::op_and: begin
					val = regs[ir[8:6]] & opb;
					writes = 1'b1;
				end
				lc3b_types_pkg::op_not: begin
					val = ~regs[ir[8:6]];
					writes = 1'b1;
				end
				lc3b_types_pkg::op_lea: begin
					val = npc + (sext(ir[8:0], 9) << 1);
					writes = 1'b1;
					sets_cc = 1'b0;  // LEA leaves CC alone
				end
				lc3b_types_pkg::op_ldr: begin
					val = model_dmem[addr[15:1]];
					writes = 1'b1;
				end
				lc3b_types_pkg::op_str: begin
					model_dmem[addr[15:1]] = regs[ir[11:9]];
					expect_q.push_back({1'b1, addr, regs[ir[11:9]]});
				end
				lc3b_types_pkg::op_br: begin
					if (|(ir[11:9] & cc)) npc = npc + (sext(ir[8:0], 9) << 1);
				end
				lc3b_types_pkg::op_jmp: npc = regs[ir[8:6]];
				default: ;
			endcase
			if (writes) begin
				regs[ir[11:9]] = val;
				expect_q.push_back({1'b0, 13'd0, ir[11:9], val});
				if (sets_cc) cc = {val[15], val == '0, !val[15] && val != '0};
			end
			pc = npc;
			steps++;
		end
		return pc == 16'(2 * (PROG_LEN - 1));
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_event(input logic is_store, input lc3b_types_pkg::lc3b_word key,
			input lc3b_types_pkg::lc3b_word data, input string name);
		logic [32:0] exp;
		assert (expect_q.size() > 0)
			else abort_run($sformatf("Unexpected %s to %h after the last expected event",
				name, key));
		exp = expect_q.pop_front();
		assert (exp == {is_store, key, data})
			else abort_run($sformatf("Fail %s #%0d: expected %s %h=%h, actual %h=%h", name,
				event_count, exp[32] ? "store" : "write", exp[31:16], exp[15:0], key, data));
		event_count++;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (wb_valid) check_event(1'b0, {13'd0, wb_dest}, wb_data, "register write");
			if (dmem_we) check_event(1'b1, dmem_addr, dmem_wdata, "store");  // Younger than WB
		end
	end

	initial begin
		int cycles;
		rst_n = 1'b0;
		lfsr = 32'hce560d29;
		event_count = 0;
		for (int k = 0; k < 32768; k++) dmem[k] <= fill_word(k);
		build_program();
		if (!run_isa_model()) abort_run("The ISA model never reached the final branch");
		repeat (10) @(posedge clk);
		#5 rst_n = 1'b1;
		@(negedge clk);
		assert (imem_addr == RESET_PC && !dmem_we && !wb_valid)
			else abort_run($sformatf("Fail reset: expected addr %h, strobes 0, actual %h, %b%b",
				RESET_PC, imem_addr, dmem_we, wb_valid));
		cycles = 0;
		while (expect_q.size() > 0 && cycles < MAX_WAIT) begin
			@(posedge clk);
			cycles++;
		end
		if (expect_q.size() > 0) begin
			abort_run($sformatf("Timeout with %0d expected events still missing",
				expect_q.size()));
		end else begin
			cycles = 0;
			while (cycles < 40) begin  // Halt loop must stay quiet
				@(posedge clk);
				cycles++;
			end
			$display("test passed");
			$finish;
		end
	end

endmodule : tb_lc3b

`default_nettype wire

//--- lc3b_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_asserts (
	input wire clk,
	input wire rst_n,
	input wire dmem_we,
	input wire ex_mem_valid,
	input wire dep_stall,
	input wire br_stall,
	input wire br_taken,
	input wire wb_valid,
	input wire lc3b_types_pkg::lc3b_word pc
);

	store_in_valid_stage: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_we |-> ex_mem_valid)
		else $error("Store strobe raised without a valid memory stage");

	// Redirect from memory overrides the stall
	stalled_pc_holds: assert property (@(posedge clk) disable iff (!rst_n)
		((dep_stall || br_stall) && !br_taken) |=> (pc == $past(pc)))
		else $error("PC moved while fetch was stalled");

	wb_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(wb_valid))
		else $error("Writeback strobe is unknown");

endmodule : lc3b_asserts

bind pipeline_datapath lc3b_asserts asserts (.clk, .rst_n, .dmem_we, .ex_mem_valid,
	.dep_stall, .br_stall, .br_taken, .wb_valid, .pc);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100  // Full clock period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;  // 50 ns high, 50 ns low
	end

endmodule : tb_clock_gen

`default_nettype wire

//--- lc3b_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_cpu #(
	parameter lc3b_types_pkg::lc3b_word RESET_PC = '0  // First fetch address
) (
	input wire clk,
	input wire rst_n,
	output lc3b_types_pkg::lc3b_word imem_addr,
	input wire lc3b_types_pkg::lc3b_word imem_rdata,
	output lc3b_types_pkg::lc3b_word dmem_addr,
	output lc3b_types_pkg::lc3b_word dmem_wdata,
	output logic dmem_we,                            // One-cycle store strobe
	input wire lc3b_types_pkg::lc3b_word dmem_rdata,
	output logic wb_valid,                           // One-cycle write strobe
	output lc3b_types_pkg::lc3b_reg wb_dest,
	output lc3b_types_pkg::lc3b_word wb_data
);

	pipeline_datapath #(
		.RESET_PC(RESET_PC)
	) datapath (
		.clk,
		.rst_n,
		.imem_addr,
		.imem_rdata,
		.dmem_addr,
		.dmem_wdata,
		.dmem_we,
		.dmem_rdata,
		.wb_valid,
		.wb_dest,
		.wb_data
	);

endmodule : lc3b_cpu

`default_nettype wire

//--- pipeline_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline_datapath #(
	parameter lc3b_types_pkg::lc3b_word RESET_PC = '0
) (
	input wire clk,
	input wire rst_n,
	output lc3b_types_pkg::lc3b_word imem_addr,
	input wire lc3b_types_pkg::lc3b_word imem_rdata,
	output lc3b_types_pkg::lc3b_word dmem_addr,
	output lc3b_types_pkg::lc3b_word dmem_wdata,
	output logic dmem_we,
	input wire lc3b_types_pkg::lc3b_word dmem_rdata,
	output logic wb_valid,
	output lc3b_types_pkg::lc3b_reg wb_dest,
	output lc3b_types_pkg::lc3b_word wb_data
);
	ctrl_if ctrl ();
	wb_if wb ();

	lc3b_types_pkg::lc3b_word pc, pc_plus2;
	lc3b_ctrl_pkg::pc_sel_t pc_sel;
	logic dep_stall, br_stall, br_taken;

	logic if_id_valid;
	lc3b_types_pkg::lc3b_word if_id_ir, if_id_pc2;
	lc3b_types_pkg::lc3b_reg src_b;
	lc3b_types_pkg::lc3b_word reg_a, reg_b;

	logic id_ex_valid, id_ex_sr2_imm, id_ex_load_reg, id_ex_load_cc;
	logic id_ex_store, id_ex_br_op, id_ex_jmp_op;
	lc3b_ctrl_pkg::alu_op_t id_ex_alu_op;
	lc3b_ctrl_pkg::wb_sel_t id_ex_wb_sel;
	lc3b_types_pkg::lc3b_word id_ex_ir, id_ex_pc2, id_ex_a, id_ex_b;
	lc3b_types_pkg::lc3b_reg id_ex_dest;

	lc3b_types_pkg::lc3b_imm5 imm5;
	lc3b_types_pkg::lc3b_offset6 off6;
	lc3b_types_pkg::lc3b_offset9 off9;
	lc3b_types_pkg::lc3b_word sext5, sext6, sext9, addr_base, addr_off, op_b, alu_f;
	logic pc_rel;

	logic ex_mem_valid, ex_mem_load_reg, ex_mem_load_cc, ex_mem_store;
	logic ex_mem_br_op, ex_mem_jmp_op;
	lc3b_ctrl_pkg::wb_sel_t ex_mem_wb_sel;
	lc3b_types_pkg::lc3b_reg ex_mem_nzp, ex_mem_dest, cc, cc_now;
	lc3b_types_pkg::lc3b_word ex_mem_alu, ex_mem_addr;

	logic mem_wb_valid, mem_wb_load_reg, mem_wb_load_cc;
	lc3b_ctrl_pkg::wb_sel_t mem_wb_wb_sel;
	lc3b_types_pkg::lc3b_reg mem_wb_dest, wb_cc;
	lc3b_types_pkg::lc3b_word mem_wb_alu, mem_wb_rdata, mem_wb_addr, wb_word;

	// Fetch
	assign imem_addr = pc;
	assign pc_plus2 = pc + 16'd2;
	always_comb begin
		pc_sel = lc3b_ctrl_pkg::pc_plus2;
		if (br_taken) pc_sel = lc3b_ctrl_pkg::pc_target;  // Redirect from memory
	end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (br_taken || !(dep_stall || br_stall)) begin
			pc <= (pc_sel == lc3b_ctrl_pkg::pc_target) ? ex_mem_addr : pc_plus2;
		end
	end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_id_valid <= 1'b0;
		end else if (!dep_stall) begin
			if_id_valid <= ~br_stall;  // Bubble while a branch is in flight
		end
	end
	always_ff @(posedge clk) begin
		if (!dep_stall) begin
			if_id_ir <= imem_rdata;
			if_id_pc2 <= pc_plus2;
		end
	end

	// Decode
	assign ctrl.ir = if_id_ir;
	assign src_b = ctrl.src_b_is_dr ? if_id_ir[11:9] : if_id_ir[2:0];
	lc3b_control_rom control_rom (.ctrl(ctrl.rom));
	lc3b_regfile regfile (.clk, .rst_n, .src_a(if_id_ir[8:6]), .src_b, .reg_a, .reg_b,
		.wb(wb.sink));
	lc3b_hazard_unit hazard (.src_a(if_id_ir[8:6]), .src_b, .uses_sr1(ctrl.uses_sr1),
		.uses_sr2(ctrl.uses_sr2), .id_valid(if_id_valid),
		.id_branch(ctrl.br_op | ctrl.jmp_op), .ex_dest(id_ex_dest), .ex_valid(id_ex_valid),
		.ex_load_reg(id_ex_load_reg), .mem_dest(ex_mem_dest), .mem_valid(ex_mem_valid),
		.mem_load_reg(ex_mem_load_reg), .wb_dest(mem_wb_dest), .wb_valid(mem_wb_valid),
		.wb_load_reg(mem_wb_load_reg), .ex_branch(id_ex_br_op | id_ex_jmp_op),
		.mem_branch(ex_mem_br_op | ex_mem_jmp_op), .dep_stall, .br_stall);
	always_ff @(posedge clk) begin
		if (!rst_n) id_ex_valid <= 1'b0;
		else id_ex_valid <= if_id_valid & ~dep_stall;  // Bubble on dependency
	end
	always_ff @(posedge clk) begin
		id_ex_alu_op <= ctrl.alu_op;
		id_ex_sr2_imm <= ctrl.sr2_imm;
		id_ex_wb_sel <= ctrl.wb_sel;
		id_ex_load_reg <= ctrl.load_reg;
		id_ex_load_cc <= ctrl.load_cc;
		id_ex_store <= ctrl.mem_write;
		id_ex_br_op <= ctrl.br_op;
		id_ex_jmp_op <= ctrl.jmp_op;
		id_ex_ir <= if_id_ir;
		id_ex_pc2 <= if_id_pc2;
		id_ex_a <= reg_a;
		id_ex_b <= reg_b;
		id_ex_dest <= if_id_ir[11:9];  // DR for every writer
	end

	// Execute
	assign imm5 = id_ex_ir[4:0];
	assign off6 = id_ex_ir[5:0];
	assign off9 = id_ex_ir[8:0];
	assign sext5 = lc3b_types_pkg::lc3b_word'(signed'(imm5));
	assign sext6 = lc3b_types_pkg::lc3b_word'(signed'(off6));
	assign sext9 = lc3b_types_pkg::lc3b_word'(signed'(off9));
	assign pc_rel = id_ex_br_op | (id_ex_wb_sel == lc3b_ctrl_pkg::wb_addr);  // BR and LEA
	assign addr_base = pc_rel ? id_ex_pc2 : id_ex_a;
	assign addr_off = id_ex_jmp_op ? '0 : (pc_rel ? sext9 : sext6) << 1;  // Word offsets
	assign op_b = id_ex_sr2_imm ? sext5 : id_ex_b;
	lc3b_alu alu (.alu_op(id_ex_alu_op), .a(id_ex_a), .b(op_b), .f(alu_f));
	always_ff @(posedge clk) begin
		if (!rst_n) ex_mem_valid <= 1'b0;
		else ex_mem_valid <= id_ex_valid;
	end
	always_ff @(posedge clk) begin
		ex_mem_wb_sel <= id_ex_wb_sel;
		ex_mem_load_reg <= id_ex_load_reg;
		ex_mem_load_cc <= id_ex_load_cc;
		ex_mem_store <= id_ex_store;
		ex_mem_br_op <= id_ex_br_op;
		ex_mem_jmp_op <= id_ex_jmp_op;
		ex_mem_nzp <= id_ex_ir[11:9];  // BR mask
		ex_mem_dest <= id_ex_dest;
		ex_mem_alu <= alu_f;
		ex_mem_addr <= addr_base + addr_off;  // Address adder
	end

	// Memory
	assign cc_now = (mem_wb_valid & mem_wb_load_cc) ? wb_cc : cc;  // CC being written now
	assign br_taken = ex_mem_valid & (ex_mem_jmp_op | (ex_mem_br_op & |(cc_now & ex_mem_nzp)));
	assign dmem_addr = ex_mem_addr;
	assign dmem_wdata = ex_mem_alu;
	assign dmem_we = ex_mem_valid & ex_mem_store;
	always_ff @(posedge clk) begin
		if (!rst_n) mem_wb_valid <= 1'b0;
		else mem_wb_valid <= ex_mem_valid;
	end
	always_ff @(posedge clk) begin
		mem_wb_wb_sel <= ex_mem_wb_sel;
		mem_wb_load_reg <= ex_mem_load_reg;
		mem_wb_load_cc <= ex_mem_load_cc;
		mem_wb_dest <= ex_mem_dest;
		mem_wb_alu <= ex_mem_alu;
		mem_wb_rdata <= dmem_rdata;  // Same-cycle read
		mem_wb_addr <= ex_mem_addr;
	end

	// Writeback
	assign wb_word = (mem_wb_wb_sel == lc3b_ctrl_pkg::wb_mem) ? mem_wb_rdata :
		(mem_wb_wb_sel == lc3b_ctrl_pkg::wb_addr) ? mem_wb_addr : mem_wb_alu;
	assign wb_cc = {wb_word[15], wb_word == '0, ~wb_word[15] & (|wb_word)};  // n z p
	assign wb.wr_en = mem_wb_valid & mem_wb_load_reg;
	assign wb.dest = mem_wb_dest;
	assign wb.data = wb_word;
	assign wb_valid = wb.wr_en;
	assign wb_dest = wb.dest;
	assign wb_data = wb.data;
	always_ff @(posedge clk) begin
		if (!rst_n) cc <= 3'b010;  // Z, matches zeroed registers
		else if (mem_wb_valid & mem_wb_load_cc) cc <= wb_cc;
	end

endmodule : pipeline_datapath

`default_nettype wire

//--- lc3b_hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_hazard_unit (
	input wire lc3b_types_pkg::lc3b_reg src_a,
	input wire lc3b_types_pkg::lc3b_reg src_b,
	input wire uses_sr1,
	input wire uses_sr2,
	input wire id_valid,
	input wire id_branch,
	input wire lc3b_types_pkg::lc3b_reg ex_dest,
	input wire ex_valid,
	input wire ex_load_reg,
	input wire lc3b_types_pkg::lc3b_reg mem_dest,
	input wire mem_valid,
	input wire mem_load_reg,
	input wire lc3b_types_pkg::lc3b_reg wb_dest,
	input wire wb_valid,
	input wire wb_load_reg,
	input wire ex_branch,
	input wire mem_branch,
	output logic dep_stall,
	output logic br_stall
);
	logic hit_a;
	logic hit_b;

	// Live writer to the same register
	function automatic logic pending(input logic live, input lc3b_types_pkg::lc3b_reg dest,
			input lc3b_types_pkg::lc3b_reg src);
		return live && (dest == src);
	endfunction

	assign hit_a = pending(ex_valid & ex_load_reg, ex_dest, src_a) |
		pending(mem_valid & mem_load_reg, mem_dest, src_a) |
		pending(wb_valid & wb_load_reg, wb_dest, src_a);
	assign hit_b = pending(ex_valid & ex_load_reg, ex_dest, src_b) |
		pending(mem_valid & mem_load_reg, mem_dest, src_b) |
		pending(wb_valid & wb_load_reg, wb_dest, src_b);

	assign dep_stall = id_valid & ((uses_sr1 & hit_a) | (uses_sr2 & hit_b));  // No forwarding
	// Fetch frozen until the branch resolves in memory
	assign br_stall = (id_valid & id_branch) | (ex_valid & ex_branch) |
		(mem_valid & mem_branch);

endmodule : lc3b_hazard_unit

`default_nettype wire

//--- lc3b_control_rom.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_control_rom (
	ctrl_if.rom ctrl
);
	lc3b_types_pkg::lc3b_opcode opcode;

	assign opcode = lc3b_types_pkg::lc3b_opcode'(ctrl.ir[15:12]);

	always_comb begin
		ctrl.alu_op = lc3b_ctrl_pkg::alu_pass_b;  // Enables all low by default
		ctrl.sr2_imm = 1'b0;
		ctrl.wb_sel = lc3b_ctrl_pkg::wb_alu;
		ctrl.load_reg = 1'b0;
		ctrl.load_cc = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.br_op = 1'b0;
		ctrl.jmp_op = 1'b0;
		ctrl.src_b_is_dr = 1'b0;
		ctrl.uses_sr1 = 1'b0;
		ctrl.uses_sr2 = 1'b0;
		case (opcode)
			lc3b_types_pkg::op_add, lc3b_types_pkg::op_and: begin
				ctrl.alu_op = (opcode == lc3b_types_pkg::op_add) ?
					lc3b_ctrl_pkg::alu_add : lc3b_ctrl_pkg::alu_and;
				ctrl.sr2_imm = ctrl.ir[5];   // imm5 form
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.uses_sr1 = 1'b1;
				ctrl.uses_sr2 = ~ctrl.ir[5];  // SR2 only in register form
			end
			lc3b_types_pkg::op_not: begin
				ctrl.alu_op = lc3b_ctrl_pkg::alu_not;
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.uses_sr1 = 1'b1;
			end
			lc3b_types_pkg::op_lea: begin
				ctrl.wb_sel = lc3b_ctrl_pkg::wb_addr;  // PC-relative, CC untouched
				ctrl.load_reg = 1'b1;
			end
			lc3b_types_pkg::op_ldr: begin
				ctrl.wb_sel = lc3b_ctrl_pkg::wb_mem;
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.uses_sr1 = 1'b1;  // Base register
			end
			lc3b_types_pkg::op_str: begin
				ctrl.mem_write = 1'b1;
				ctrl.src_b_is_dr = 1'b1;  // Store data from IR[11:9]
				ctrl.uses_sr1 = 1'b1;
				ctrl.uses_sr2 = 1'b1;
			end
			lc3b_types_pkg::op_br: ctrl.br_op = 1'b1;
			lc3b_types_pkg::op_jmp: begin
				ctrl.jmp_op = 1'b1;
				ctrl.uses_sr1 = 1'b1;  // Target register
			end
			default: ;
		endcase
	end

endmodule : lc3b_control_rom

`default_nettype wire

//--- lc3b_alu.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_alu (
	input wire lc3b_ctrl_pkg::alu_op_t alu_op,
	input wire lc3b_types_pkg::lc3b_word a,
	input wire lc3b_types_pkg::lc3b_word b,
	output lc3b_types_pkg::lc3b_word f
);

	always_comb begin
		case (alu_op)
			lc3b_ctrl_pkg::alu_add: f = a + b;     // Wraps at 16 bits
			lc3b_ctrl_pkg::alu_and: f = a & b;
			lc3b_ctrl_pkg::alu_not: f = ~a;        // B ignored
			default: f = b;                       // Pass B for STR data
		endcase
	end

endmodule : lc3b_alu

`default_nettype wire

//--- lc3b_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_regfile (
	input wire clk,
	input wire rst_n,
	input wire lc3b_types_pkg::lc3b_reg src_a,
	input wire lc3b_types_pkg::lc3b_reg src_b,
	output lc3b_types_pkg::lc3b_word reg_a,
	output lc3b_types_pkg::lc3b_word reg_b,
	wb_if.sink wb
);
	lc3b_types_pkg::lc3b_word regs [8];  // R0..R7

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;  // All registers start at zero
			end
		end else if (wb.wr_en) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// Same-cycle write visible to decode
	assign reg_a = (wb.wr_en && (wb.dest == src_a)) ? wb.data : regs[src_a];
	assign reg_b = (wb.wr_en && (wb.dest == src_b)) ? wb.data : regs[src_b];

endmodule : lc3b_regfile

`default_nettype wire

//--- lc3b_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// Decode IR out to the ROM, control word back
interface ctrl_if;
	lc3b_types_pkg::lc3b_word ir;
	lc3b_ctrl_pkg::alu_op_t alu_op;
	logic sr2_imm;                  // imm5 as operand B
	lc3b_ctrl_pkg::wb_sel_t wb_sel;
	logic load_reg;
	logic load_cc;
	logic mem_write;
	logic br_op;
	logic jmp_op;
	logic src_b_is_dr;              // STR reads IR[11:9]
	logic uses_sr1;
	logic uses_sr2;

	modport rom (input ir, output alu_op, sr2_imm, wb_sel, load_reg, load_cc,
		mem_write, br_op, jmp_op, src_b_is_dr, uses_sr1, uses_sr2);
	modport dp (output ir, input alu_op, sr2_imm, wb_sel, load_reg, load_cc,
		mem_write, br_op, jmp_op, src_b_is_dr, uses_sr1, uses_sr2);
endinterface : ctrl_if

// Register write from the writeback stage
interface wb_if;
	logic wr_en;
	lc3b_types_pkg::lc3b_reg dest;
	lc3b_types_pkg::lc3b_word data;

	modport src (output wr_en, dest, data);
	modport sink (input wr_en, dest, data);
endinterface : wb_if

`default_nettype wire

//--- lc3b_ctrl_pkg.sv
`default_nettype none

package lc3b_ctrl_pkg;

	// ALU function
	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass_b  // Store data goes through here
	} alu_op_t;

	// Register write source in writeback
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_addr  // LEA result
	} wb_sel_t;

	// Next PC source
	typedef enum logic {
		pc_plus2,
		pc_target  // Resolved branch or JMP in memory
	} pc_sel_t;

endpackage : lc3b_ctrl_pkg

`default_nettype wire

//--- lc3b_types_pkg.sv
`default_nettype none

package lc3b_types_pkg;

	typedef logic [15:0] lc3b_word;  // Data and address word
	typedef logic [2:0] lc3b_reg;    // Register index or n,z,p triple

	typedef logic [4:0] lc3b_imm5;     // ADD/AND immediate
	typedef logic [5:0] lc3b_offset6;  // LDR/STR base offset
	typedef logic [8:0] lc3b_offset9;  // BR/LEA PC offset

	// Opcodes of the supported subset, IR[15:12]
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_lea = 4'b1110
	} lc3b_opcode;

endpackage : lc3b_types_pkg

`default_nettype wire
